// File: src/bexkat_pkg.sv
`default_nettype none

package bexkat_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int BE_W       = 4;

  localparam logic [WORD_W-1:0] RESET_PC = 32'hffffc000; // monitor base
  localparam logic BIG_ENDIAN = 1'b1;

  localparam logic [2:0] MODE_REG    = 3'h0;
  localparam logic [2:0] MODE_REGIND = 3'h1;
  localparam logic [2:0] MODE_IMM    = 3'h2;

  // register mode
  localparam logic [7:0] OP_NOP      = 8'h00;
  localparam logic [7:0] OP_CMP      = 8'h02;
  localparam logic [7:0] OP_INC      = 8'h03;
  localparam logic [7:0] OP_DEC      = 8'h04;
  localparam logic [7:0] OP_MOV      = 8'h07;
  localparam logic [7:0] OP_COM      = 8'h08;
  localparam logic [7:0] OP_NEG      = 8'h09;
  localparam logic [7:0] OP_ALU_BASE = 8'h20; // low nibble is alu func

  // immediate mode
  localparam logic [7:0] OP_BRA  = 8'h00;
  localparam logic [7:0] OP_BEQ  = 8'h01;
  localparam logic [7:0] OP_BNE  = 8'h02;
  localparam logic [7:0] OP_BGTU = 8'h03;
  localparam logic [7:0] OP_BGT  = 8'h04;
  localparam logic [7:0] OP_BGE  = 8'h05;
  localparam logic [7:0] OP_BLE  = 8'h06;
  localparam logic [7:0] OP_BLT  = 8'h07;
  localparam logic [7:0] OP_BGEU = 8'h08;
  localparam logic [7:0] OP_BLTU = 8'h09;
  localparam logic [7:0] OP_BLEU = 8'h0a;
  localparam logic [7:0] OP_BRN  = 8'h0b;
  localparam logic [7:0] OP_LDIS = 8'h0c;
  localparam logic [7:0] OP_LDIU = 8'h0d;

  // register indirect mode
  localparam logic [7:0] OP_ST_L = 8'h00;
  localparam logic [7:0] OP_LD_L = 8'h01;
  localparam logic [7:0] OP_ST_B = 8'h04;
  localparam logic [7:0] OP_LD_B = 8'h05;
  localparam logic [7:0] OP_LDA  = 8'h0a;
  localparam logic [7:0] OP_JMP  = 8'h0b;

  localparam logic [3:0] ALU_AND = 4'h0;
  localparam logic [3:0] ALU_OR  = 4'h1;
  localparam logic [3:0] ALU_ADD = 4'h2;
  localparam logic [3:0] ALU_SUB = 4'h3;
  localparam logic [3:0] ALU_XOR = 4'h4;
  localparam logic [3:0] ALU_LSL = 4'h5;
  localparam logic [3:0] ALU_LSR = 4'h6;
  localparam logic [3:0] ALU_ASR = 4'h7;

  localparam logic [3:0] ST_FETCH      = 4'h0;
  localparam logic [3:0] ST_FETCH_WAIT = 4'h1;
  localparam logic [3:0] ST_EVAL       = 4'h2;
  localparam logic [3:0] ST_MEM_WAIT   = 4'h3;
  localparam logic [3:0] ST_LOAD_WB    = 4'h4;
  localparam logic [3:0] ST_FAULT      = 4'h5;

  localparam logic [BE_W-1:0] BE_LONG = 4'b1111;

  typedef struct packed {
    logic [2:0] mode;
    logic [7:0] op;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
    logic [5:0] unused;
  } reg_fields_t;

  typedef struct packed {
    logic [2:0]  mode;
    logic [7:0]  op;
    logic [4:0]  ra;
    logic [15:0] imm; // low 11 bits double as indirect displacement
  } imm_fields_t;

  typedef union packed {
    reg_fields_t rg;
    imm_fields_t im;
  } instr_u;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } flags_t;

endpackage

`default_nettype wire

// File: src/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if import bexkat_pkg::*; ();

  logic              start_read;
  logic              start_write;
  logic [WORD_W-1:0] addr;
  logic [WORD_W-1:0] wdata;
  logic [BE_W-1:0]   be;
  logic              is_byte;
  logic              done;
  logic              capture;
  logic [BE_W-1:0]   lane_be;
  logic [WORD_W-1:0] load_data;

  modport ctrl (output start_read, start_write, addr, wdata, be, is_byte,
                input done, load_data);

  modport bus (input start_read, start_write, addr, wdata, be,
               output done, capture, lane_be);

  modport align (input capture, lane_be, is_byte,
                 output load_data);

endinterface

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import bexkat_pkg::*; (
  input  wire logic [WORD_W-1:0] a,
  input  wire logic [WORD_W-1:0] b,
  input  wire logic [3:0]        func,
  output logic      [WORD_W-1:0] out,
  output flags_t                 flags
);

  logic [WORD_W:0] sum;
  logic [WORD_W:0] diff;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b}; // msb is borrow

  always_comb begin
    out            = '0;
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    case (func)
      ALU_AND: out = a & b;
      ALU_OR:  out = a | b;
      ALU_ADD: begin
        out            = sum[WORD_W-1:0];
        flags.carry    = sum[WORD_W];
        flags.overflow = (a[WORD_W-1] == b[WORD_W-1]) && (out[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_SUB: begin
        out            = diff[WORD_W-1:0];
        flags.carry    = diff[WORD_W];
        flags.overflow = (a[WORD_W-1] != b[WORD_W-1]) && (out[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_XOR: out = a ^ b;
      ALU_LSL: out = a << b[4:0];
      ALU_LSR: out = a >> b[4:0];
      ALU_ASR: out = $signed(a) >>> b[4:0];
      default: out = '0;
    endcase
    flags.negative = out[WORD_W-1];
    flags.zero     = (out == '0);
  end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import bexkat_pkg::*; (
  input  wire logic [REG_ADDR_W-1:0] rd_addr1,
  input  wire logic [REG_ADDR_W-1:0] rd_addr2,
  input  wire logic [REG_ADDR_W-1:0] wr_addr,
  input  wire logic                  csi_clk,
  input  wire logic                  rsi_reset_n,
  input  wire logic                  wr_en,
  input  wire logic [WORD_W-1:0]     wr_data,
  output logic      [WORD_W-1:0]     rd_data1,
  output logic      [WORD_W-1:0]     rd_data2
);

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [WORD_W-1:0] regs [NUM_REGS];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // no bypass, reads see the old value in the write cycle
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

// File: src/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm import bexkat_pkg::*; (
  input  wire logic                  csi_clk,
  input  wire logic                  rsi_reset_n,
  input  wire logic [WORD_W-1:0]     rd_data1,
  input  wire logic [WORD_W-1:0]     rd_data2,
  input  wire logic [WORD_W-1:0]     alu_out,
  input  wire flags_t                alu_flags,
  output logic      [REG_ADDR_W-1:0] rd_addr1,
  output logic      [REG_ADDR_W-1:0] rd_addr2,
  output logic      [REG_ADDR_W-1:0] wr_addr,
  output logic                       wr_en,
  output logic      [WORD_W-1:0]     wr_data,
  output logic      [WORD_W-1:0]     alu_a,
  output logic      [WORD_W-1:0]     alu_b,
  output logic      [3:0]            alu_func,
  mem_if.ctrl                        mem
);

  logic [3:0]        state, state_next;
  logic [WORD_W-1:0] pc, pc_next;
  instr_u            ir, ir_next;
  flags_t            ccr, ccr_next;
  logic [WORD_W-1:0] mdr;
  logic [WORD_W-1:0] imm_sx, imm_zx, disp_sx;
  logic              take;
  logic              is_load;

  assign imm_sx  = {{(WORD_W-16){ir.im.imm[15]}}, ir.im.imm};
  assign imm_zx  = {{(WORD_W-16){1'b0}}, ir.im.imm};
  assign disp_sx = {{(WORD_W-11){ir.im.imm[10]}}, ir.im.imm[10:0]};
  assign is_load = (ir.rg.op == OP_LD_L) || (ir.rg.op == OP_LD_B);
  assign mem.is_byte = (state == ST_MEM_WAIT) && (ir.rg.op == OP_LD_B);

  // branch conditions, carry is borrow after cmp
  always_comb begin
    case (ir.im.op)
      OP_BRA:  take = 1'b1;
      OP_BEQ:  take = ccr.zero;
      OP_BNE:  take = ~ccr.zero;
      OP_BGTU: take = ~(ccr.zero | ccr.carry);
      OP_BGT:  take = ~(ccr.zero | (ccr.negative ^ ccr.overflow));
      OP_BGE:  take = ~(ccr.negative ^ ccr.overflow);
      OP_BLE:  take = ccr.zero | (ccr.negative ^ ccr.overflow);
      OP_BLT:  take = ccr.negative ^ ccr.overflow;
      OP_BGEU: take = ~ccr.carry;
      OP_BLTU: take = ccr.carry;
      OP_BLEU: take = ccr.carry | ccr.zero;
      OP_BRN:  take = 1'b0;
      default: take = 1'b0;
    endcase
  end

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state <= ST_FETCH;
      pc    <= RESET_PC;
      ir    <= '0;
      ccr   <= '0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
      ir    <= ir_next;
      ccr   <= ccr_next;
    end
  end

  always_ff @(posedge csi_clk) begin
    if (state == ST_MEM_WAIT && mem.done)
      mdr <= mem.load_data;
  end

  always_comb begin
    state_next      = state;
    pc_next         = pc;
    ir_next         = ir;
    ccr_next        = ccr;
    mem.start_read  = 1'b0;
    mem.start_write = 1'b0;
    mem.addr        = pc;
    mem.wdata       = '0;
    mem.be          = BE_LONG;
    rd_addr1        = ir.rg.rb;
    rd_addr2        = ir.rg.rc;
    wr_addr         = ir.rg.ra;
    wr_en           = 1'b0;
    wr_data         = alu_out;
    alu_a           = rd_data1;
    alu_b           = rd_data2;
    alu_func        = ALU_ADD;

    case (state)
      ST_FETCH: begin
        mem.start_read = 1'b1;
        state_next     = ST_FETCH_WAIT;
      end
      ST_FETCH_WAIT: begin
        if (mem.done) begin
          ir_next    = mem.load_data;
          pc_next    = pc + 32'd4;
          state_next = ST_EVAL;
        end
      end
      ST_EVAL: begin
        state_next = ST_FETCH;
        case (ir.rg.mode)
          MODE_REG: begin
            case (ir.rg.op)
              OP_NOP: ;
              OP_CMP: begin
                rd_addr1 = ir.rg.ra;
                rd_addr2 = ir.rg.rb;
                alu_func = ALU_SUB;
                ccr_next = alu_flags;
              end
              OP_INC, OP_DEC: begin
                rd_addr1 = ir.rg.ra;
                alu_b    = 32'd1;
                alu_func = (ir.rg.op == OP_DEC) ? ALU_SUB : ALU_ADD;
                wr_en    = 1'b1;
              end
              OP_MOV: begin
                wr_data = rd_data1;
                wr_en   = 1'b1;
              end
              OP_COM: begin
                wr_data = ~rd_data1;
                wr_en   = 1'b1;
              end
              OP_NEG: begin
                wr_data = -rd_data1;
                wr_en   = 1'b1;
              end
              default: begin
                if (ir.rg.op[7:3] == OP_ALU_BASE[7:3]) begin // funcs 8-15 undefined
                  alu_func = ir.rg.op[3:0];
                  wr_en    = 1'b1;
                end else begin
                  state_next = ST_FAULT;
                end
              end
            endcase
          end
          MODE_IMM: begin
            if (ir.im.op inside {[OP_BRA:OP_BRN]}) begin
              if (take)
                pc_next = pc + imm_sx; // pc already points past this word
            end else if (ir.im.op == OP_LDIS) begin
              wr_data = imm_sx;
              wr_en   = 1'b1;
            end else if (ir.im.op == OP_LDIU) begin
              wr_data = imm_zx;
              wr_en   = 1'b1;
            end else begin
              state_next = ST_FAULT;
            end
          end
          MODE_REGIND: begin
            alu_b    = disp_sx; // rb + displacement
            rd_addr2 = ir.rg.ra;
            mem.addr = alu_out;
            case (ir.rg.op)
              OP_ST_L: begin
                mem.start_write = 1'b1;
                mem.wdata       = rd_data2;
                state_next      = ST_MEM_WAIT;
              end
              OP_LD_L: begin
                mem.start_read = 1'b1;
                state_next     = ST_MEM_WAIT;
              end
              OP_ST_B: begin
                mem.start_write = 1'b1;
                mem.wdata       = WORD_W'(rd_data2[7:0]) << {~alu_out[1:0], 3'b000};
                mem.be          = 4'b1000 >> alu_out[1:0]; // addr 0 is top byte
                state_next      = ST_MEM_WAIT;
              end
              OP_LD_B: begin
                mem.start_read = 1'b1;
                mem.be         = 4'b1000 >> alu_out[1:0];
                state_next     = ST_MEM_WAIT;
              end
              OP_LDA: wr_en = 1'b1;
              OP_JMP: pc_next = alu_out;
              default: state_next = ST_FAULT;
            endcase
          end
          default: state_next = ST_FAULT;
        endcase
      end
      ST_MEM_WAIT: begin
        if (mem.done)
          state_next = is_load ? ST_LOAD_WB : ST_FETCH;
      end
      ST_LOAD_WB: begin
        wr_data    = mdr;
        wr_en      = 1'b1;
        state_next = ST_FETCH;
      end
      ST_FAULT: state_next = ST_FAULT; // stuck until reset
      default: state_next = ST_FAULT;
    endcase
  end

endmodule

`default_nettype wire

// File: src/mem_request.sv
`timescale 1ns/1ps
`default_nettype none

module mem_request import bexkat_pkg::*; (
  input  wire logic              csi_clk,
  input  wire logic              rsi_reset_n,
  input  wire logic              waitrequest,
  output logic      [WORD_W-1:0] address,
  output logic                   read,
  output logic                   write,
  output logic      [WORD_W-1:0] writedata,
  output logic      [BE_W-1:0]   byteenable,
  mem_if.bus                     mem
);

  logic [WORD_W-1:0] wdata_q;
  logic [BE_W-1:0]   be_q;
  logic              accept;

  assign accept = (read | write) & ~waitrequest;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      read     <= 1'b0;
      write    <= 1'b0;
      be_q     <= '0;
      mem.done <= 1'b0;
    end else begin
      mem.done <= 1'b0;
      if (mem.start_read || mem.start_write) begin
        read  <= mem.start_read;
        write <= mem.start_write;
        be_q  <= mem.be;
      end else if (accept) begin
        read     <= 1'b0;
        write    <= 1'b0;
        be_q     <= '0;
        mem.done <= 1'b1;
      end
    end
  end

  always_ff @(posedge csi_clk) begin
    if (mem.start_read || mem.start_write) begin
      address <= mem.addr;
      wdata_q <= mem.wdata;
    end
  end

  assign mem.capture = read & ~waitrequest; // read data valid this cycle
  assign mem.lane_be = be_q;

  // lanes are built big-endian, swapped for a little-endian bus
  assign writedata  = BIG_ENDIAN ? wdata_q
                    : {wdata_q[7:0], wdata_q[15:8], wdata_q[23:16], wdata_q[31:24]};
  assign byteenable = BIG_ENDIAN ? be_q : {be_q[0], be_q[1], be_q[2], be_q[3]};

endmodule

`default_nettype wire

// File: src/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align import bexkat_pkg::*; (
  input  wire logic              csi_clk,
  input  wire logic              rsi_reset_n,
  input  wire logic [WORD_W-1:0] readdata,
  mem_if.align                   mem
);

  logic [WORD_W-1:0] lanes;
  logic [WORD_W-1:0] ext;

  assign lanes = BIG_ENDIAN ? readdata
               : {readdata[7:0], readdata[15:8], readdata[23:16], readdata[31:24]};

  // pick the enabled byte and sign extend
  always_comb begin
    ext = lanes;
    if (mem.is_byte) begin
      case (mem.lane_be)
        4'b1000: ext = {{(WORD_W-8){lanes[31]}}, lanes[31:24]};
        4'b0100: ext = {{(WORD_W-8){lanes[23]}}, lanes[23:16]};
        4'b0010: ext = {{(WORD_W-8){lanes[15]}}, lanes[15:8]};
        4'b0001: ext = {{(WORD_W-8){lanes[7]}}, lanes[7:0]};
        default: ext = lanes;
      endcase
    end
  end

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n)
      mem.load_data <= '0;
    else if (mem.capture)
      mem.load_data <= ext;
  end

endmodule

`default_nettype wire

// File: src/bexkat_top.sv
`timescale 1ns/1ps
`default_nettype none

module bexkat_top import bexkat_pkg::*; (
  input  wire logic              csi_clk,
  input  wire logic              rsi_reset_n,
  input  wire logic              avm_m0_waitrequest,
  input  wire logic [WORD_W-1:0] avm_m0_readdata,
  output logic [WORD_W-1:0]      avm_m0_address,
  output logic                   avm_m0_read,
  output logic                   avm_m0_write,
  output logic [WORD_W-1:0]      avm_m0_writedata,
  output logic [BE_W-1:0]        avm_m0_byteenable
);

  logic [REG_ADDR_W-1:0] rd_addr1, rd_addr2, wr_addr;
  logic                  wr_en;
  logic [WORD_W-1:0]     wr_data, rd_data1, rd_data2;
  logic [WORD_W-1:0]     alu_a, alu_b, alu_out;
  logic [3:0]            alu_func;
  flags_t                alu_flags;

  mem_if m_if ();

  control_fsm u_ctrl (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .alu_out     (alu_out),
    .alu_flags   (alu_flags),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .wr_addr     (wr_addr),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_func    (alu_func),
    .mem         (m_if)
  );

  reg_file u_regs (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .wr_addr     (wr_addr),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2)
  );

  alu u_alu (
    .a     (alu_a),
    .b     (alu_b),
    .func  (alu_func),
    .out   (alu_out),
    .flags (alu_flags)
  );

  mem_request u_req (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .waitrequest (avm_m0_waitrequest),
    .address     (avm_m0_address),
    .read        (avm_m0_read),
    .write       (avm_m0_write),
    .writedata   (avm_m0_writedata),
    .byteenable  (avm_m0_byteenable),
    .mem         (m_if)
  );

  load_align u_align (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .readdata    (avm_m0_readdata),
    .mem         (m_if)
  );

endmodule

`default_nettype wire

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import bexkat_pkg::*; (
  input  wire logic              csi_clk,
  input  wire logic [WORD_W-1:0] address,
  input  wire logic              read,
  input  wire logic              write,
  input  wire logic [WORD_W-1:0] writedata,
  input  wire logic [BE_W-1:0]   byteenable,
  output logic                   waitrequest,
  output logic      [WORD_W-1:0] readdata
);

  logic [WORD_W-1:0] mem [256];
  logic [31:0]       rng_state;
  logic [7:0]        idx;
  int                wait_left;
  logic              busy;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    logic [7:0] a;
    for (int i = 0; i < 256; i++) begin
      a = 8'(i);
      mem[i] = {a, ~a, a ^ 8'h5a, a}; // fill depends on word index
    end
    $readmemh("verif/bexkat_vectors.hex", mem);
    rng_state   = 32'h870e;
    wait_left   = 0;
    busy        = 1'b0;
    waitrequest = 1'b1; // idle high until a request is seen
    readdata    = '0;
  end

  always @(negedge csi_clk) begin
    idx = address[9:2];
    if (read || write) begin
      if (!busy) begin
        busy      = 1'b1;
        rng_state = xorshift(rng_state);
        wait_left = int'(rng_state[1:0]); // 0 to 3 wait cycles
      end else if (wait_left > 0) begin
        wait_left = wait_left - 1;
      end
      if (wait_left == 0) begin
        waitrequest <= 1'b0;
        readdata    <= mem[idx];
        if (write) begin
          for (int b = 0; b < BE_W; b++)
            if (byteenable[b])
              mem[idx][b*8 +: 8] = writedata[b*8 +: 8];
        end
      end else begin
        waitrequest <= 1'b1;
      end
    end else begin
      busy = 1'b0;
      waitrequest <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_bexkat.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bexkat import bexkat_pkg::*; ();

  logic              csi_clk;
  logic              rsi_reset_n;
  logic              avm_m0_waitrequest;
  logic [WORD_W-1:0] avm_m0_readdata;
  logic [WORD_W-1:0] avm_m0_address;
  logic              avm_m0_read;
  logic              avm_m0_write;
  logic [WORD_W-1:0] avm_m0_writedata;
  logic [BE_W-1:0]   avm_m0_byteenable;

  logic [WORD_W-1:0] vec [256];
  int                prog_len, num_recs, rec_idx, grp, fetches_after;
  int                checks, errors, grp_err_base, stall_errs, cycles, limit;
  logic              hold_pending, timed_out, quiet_fail;
  logic [WORD_W-1:0] held_addr, held_data;
  logic [BE_W-1:0]   held_be;
  logic              held_rd, held_wr;
  int                group_last [4] = '{1, 4, 7, 10};
  string             group_name [4] = '{"immediates", "alu and unary ops",
                                        "compare and branch", "byte access"};

  bexkat_top u_dut (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .avm_m0_waitrequest (avm_m0_waitrequest),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_byteenable  (avm_m0_byteenable)
  );

  tb_mem_model u_mem (
    .csi_clk     (csi_clk),
    .address     (avm_m0_address),
    .read        (avm_m0_read),
    .write       (avm_m0_write),
    .writedata   (avm_m0_writedata),
    .byteenable  (avm_m0_byteenable),
    .waitrequest (avm_m0_waitrequest),
    .readdata    (avm_m0_readdata)
  );

  task automatic word_check(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic be_check(input string name, input logic [BE_W-1:0] got,
                          input logic [BE_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic strobe_check(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // bus monitor, sees the values settled before the edge
  always @(posedge csi_clk) begin
    int e0;
    if (rsi_reset_n) begin
      if (hold_pending) begin
        e0 = errors;
        word_check("avm_m0_address", avm_m0_address, held_addr);
        strobe_check("avm_m0_read", avm_m0_read, held_rd);
        strobe_check("avm_m0_write", avm_m0_write, held_wr);
        word_check("avm_m0_writedata", avm_m0_writedata, held_data);
        be_check("avm_m0_byteenable", avm_m0_byteenable, held_be);
        stall_errs += errors - e0;
      end
      hold_pending = (avm_m0_read || avm_m0_write) && avm_m0_waitrequest;
      held_addr    = avm_m0_address;
      held_data    = avm_m0_writedata;
      held_be      = avm_m0_byteenable;
      held_rd      = avm_m0_read;
      held_wr      = avm_m0_write;

      if (avm_m0_write && !avm_m0_waitrequest) begin
        if (rec_idx >= num_recs) begin
          errors++;
          $display("write at %0t after the last expected record, address %h",
                   $time, avm_m0_address);
        end else begin
          word_check("avm_m0_address", avm_m0_address, vec[128 + 3*rec_idx]);
          word_check("avm_m0_writedata", avm_m0_writedata, vec[129 + 3*rec_idx]);
          be_check("avm_m0_byteenable", avm_m0_byteenable,
                   vec[130 + 3*rec_idx][BE_W-1:0]);
          rec_idx++;
          if (grp < 4 && rec_idx == group_last[grp] + 1) begin
            $display("test %s: %s", group_name[grp],
                     (errors == grp_err_base) ? "ok" : "failed");
            grp_err_base = errors;
            grp++;
          end
        end
      end
      if (avm_m0_read && !avm_m0_waitrequest && rec_idx == num_recs)
        fetches_after++; // fetch of the undefined word
    end
  end

  initial begin
    csi_clk = 1'b0;
    forever #10 csi_clk = ~csi_clk;
  end

  initial begin
    rsi_reset_n   = 1'b0;
    rec_idx       = 0;
    grp           = 0;
    fetches_after = 0;
    checks        = 0;
    errors        = 0;
    grp_err_base  = 0;
    stall_errs    = 0;
    cycles        = 0;
    hold_pending  = 1'b0;
    quiet_fail    = 1'b0;
    $readmemh("verif/bexkat_vectors.hex", vec);
    prog_len = int'(vec[127]);
    num_recs = 0;
    while (num_recs < 40 && vec[128 + 3*num_recs] !== 32'hffffffff)
      num_recs++;
    limit = prog_len * 10;

    repeat (5) @(posedge csi_clk);
    @(negedge csi_clk);
    rsi_reset_n = 1'b1;

    while (!(rec_idx == num_recs && fetches_after >= 1) && cycles < limit) begin
      @(negedge csi_clk);
      cycles++;
    end
    timed_out = (cycles >= limit);
    if (timed_out) begin
      $display("timeout after %0d cycles, %0d of %0d writes seen",
               cycles, rec_idx, num_recs);
    end else begin
      repeat (50) begin
        @(negedge csi_clk);
        if (avm_m0_read || avm_m0_write)
          quiet_fail = 1'b1;
      end
      if (quiet_fail) begin
        errors++;
        $display("core issued a bus request after the undefined instruction");
      end
    end

    $display("test bus stall hold: %s", (stall_errs == 0) ? "ok" : "failed");
    $display("test fault halt: %s", (!quiet_fail && !timed_out) ? "ok" : "failed");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/bexkat_pkg.sv
src/mem_if.sv
src/alu.sv
src/reg_file.sv
src/control_fsm.sv
src/mem_request.sv
src/load_align.sv
src/bexkat_top.sv
verif/tb_mem_model.sv
verif/tb_bexkat.sv

// File: run.sh
#!/bin/sh
# build and run the bexkat testbench with Verilator
set -e

verilator --binary --timing -f list.f --top-module tb_bexkat -o sim_bexkat

out=$(./obj_dir/sim_bexkat)
echo "$out"

# grep returns non-zero when the pass line is missing
echo "$out" | grep -q '^\*\*\* TEST PASSED \*\*\*$'

// File: verif/bexkat_vectors.hex
// @000 program words from the boot address, @07f program length,
// @080 write records as address, data, byte enable; address ffffffff ends the list
@000
41818001 41a28001 20010100 20020104
04430880 00630000 20030108 04840880
01252000 20050118 01061000 00860000
20060110 00e70800 00411000 40e00004
200701f0 40600004 200701f4 41200004
20070114 40a00004 20050118 40200004
2003011c 21480120 20814001 20864002
20a94002 20090124 e0000000
@07f
0000001f
@080
00000100 ffff8001 0000000f
00000104 00008001 0000000f
00000108 00000003 0000000f
00000118 00010000 0000000f
00000110 ffff7ffd 0000000f
00000114 ffff8001 0000000f
00000118 00010000 0000000f
0000011c 00000003 0000000f
00000121 00010000 00000004
00000122 0000fd00 00000002
00000124 fffffffd 0000000f
ffffffff
